// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = ddc_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -x "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/ddc_props.sv
`timescale 1ns/1ps

// bound checks on the output strobe and on the reset state of ddc_top
module ddc_props #(
   parameter int DECIM_LOG2 = 4
) (
   input logic             clk,
   input logic             reset,
   input logic             out_strobe,
   input ddc_pkg::iq_out_t baseband
);
   import ddc_pkg::*;

   localparam int PERIOD = 1 << DECIM_LOG2;   // output rate divider

   int violations = 0;   // failed assertion count

   // ########################################
   // reset behavior
   // ########################################
   a_reset_strobe: assert property (@(posedge clk) reset |=> !out_strobe)
      else begin
         $error("out_strobe high after a reset cycle");
         violations++;
      end

   a_reset_data: assert property (@(posedge clk) reset |=> baseband == '0)
      else begin
         $error("baseband not cleared by reset");
         violations++;
      end

   // ########################################
   // strobe timing
   // ########################################
   a_strobe_width: assert property (@(posedge clk) disable iff (reset)
         out_strobe |=> !out_strobe)
      else begin
         $error("out_strobe wider than one cycle");
         violations++;
      end

   a_strobe_period: assert property (@(posedge clk) disable iff (reset)
         out_strobe |-> ##PERIOD out_strobe)
      else begin
         $error("out_strobe missing one period after the last pulse");
         violations++;
      end

   // output only moves together with a pulse
   a_hold: assert property (@(posedge clk) disable iff (reset)
         !out_strobe |-> $stable(baseband))
      else begin
         $error("baseband changed between strobes");
         violations++;
      end

endmodule

bind ddc_top ddc_props #(.DECIM_LOG2(DECIM_LOG2)) u_props (
   .clk        (clk),
   .reset      (reset),
   .out_strobe (out_strobe),
   .baseband   (baseband)
);

// File: bench/ddc_tb.sv
`timescale 1ns/1ps

module ddc_tb;
   import ddc_pkg::*;

   localparam int          DECIM_LOG2     = 4;
   localparam int          DECIM          = 1 << DECIM_LOG2;
   localparam int          RESET_CYCLES   = 8;
   localparam int          SETTLE         = CORDIC_LATENCY + 3*DECIM + 4;   // constant input
   localparam int          N_TESTS        = 6;
   localparam int          TEST_BUDGET    = 400;                           // cycles per test
   localparam int          TIMEOUT_CYCLES = N_TESTS*TEST_BUDGET + 100;
   localparam int          TOL            = 6;                             // lsb per component
   localparam logic [31:0] SEED           = 32'hcc3c;

   logic               clk;
   logic               reset;
   iq_in_t             sample_in;
   logic [FREQ_W-1:0]  freq_word;
   logic [PHASE_W-1:0] phase_offset;
   iq_out_t            baseband;
   logic               out_strobe;

   int cycle_count  = 0;
   int test_errors  = 0;   // errors in the running test
   int fail_count   = 0;
   int tests_run    = 0;
   int tests_passed = 0;

   ddc_top #(.DECIM_LOG2(DECIM_LOG2)) dut (
      .clk          (clk),
      .reset        (reset),
      .sample_in    (sample_in),
      .freq_word    (freq_word),
      .phase_offset (phase_offset),
      .baseband     (baseband),
      .out_strobe   (out_strobe)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // run limit
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout, run stopped after %0d cycles", cycle_count);
         $display("Testbench failed");
         $finish;
      end
   end

   // ########################################
   // helpers
   // ########################################
   task automatic step();   // inputs change and outputs are read 1 ns after the edge
      @(posedge clk);
      #1;
   endtask

   task automatic wait_strobe();
      int n;
      n = 0;
      do begin
         step();
         n++;
      end while (!out_strobe && n < 2*DECIM);
      a_strobe_seen: assert (out_strobe)
         else begin
            $display("no out_strobe seen within %0d cycles", n);
            test_errors++;
         end
   endtask

   // rounded gain * v from the fixed-point gain
   function automatic int gain_scale(input int v);
      return (v * CORDIC_GAIN_NUM + 2048) >>> 12;
   endfunction

   function automatic int rand_component(input int span);
      return int'($urandom % (2*span + 1)) - span;
   endfunction

   function automatic int big_component();   // keeps |sample| well above the lsb
      int m;
      m = 4000 + int'($urandom % 12001);
      return ($urandom & 1) ? -m : m;
   endfunction

   task automatic drive_and_settle(input int si, input int sq,
                                   input logic [FREQ_W-1:0] fw,
                                   input logic [PHASE_W-1:0] po);
      sample_in.i  = SAMPLE_W'(si);
      sample_in.q  = SAMPLE_W'(sq);
      freq_word    = fw;
      phase_offset = po;
      repeat (SETTLE) step();
      wait_strobe();
   endtask

   task automatic check_near(input string name, input int got, input int expv);
      logic [OUT_W-1:0] got_h;
      logic [OUT_W-1:0] exp_h;
      got_h = got[OUT_W-1:0];
      exp_h = expv[OUT_W-1:0];
      a_near: assert (got >= expv - TOL && got <= expv + TOL)
         else begin
            $display("ERROR %s got %h expected %h", name, got_h, exp_h);
            test_errors++;
         end
   endtask

   task automatic check_iq(input int exp_i, input int exp_q);
      check_near("baseband.i", int'(baseband.i), exp_i);
      check_near("baseband.q", int'(baseband.q), exp_q);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %-12s pass", name);
      end else begin
         $display("test %-12s FAIL with %0d errors", name, test_errors);
      end
      fail_count += test_errors;
      test_errors = 0;
   endtask

   // ########################################
   // tests
   // ########################################
   initial begin
      int      n;
      int      si;
      int      sq;
      real     g;
      real     exp_mag;
      real     got_mag;
      longint  got_l;
      longint  exp_l;

      void'($urandom(SEED));
      g            = real'(CORDIC_GAIN_NUM) / 4096.0;
      reset        = 1'b1;
      sample_in    = '0;
      freq_word    = '0;
      phase_offset = '0;

      // reset state, then the first strobe at DECIM+1 cycles
      repeat (RESET_CYCLES) begin
         step();
         a_in_reset: assert (!out_strobe && baseband == '0)
            else begin
               $display("ERROR out_strobe/baseband in reset got %h/%h expected 0/0",
                        out_strobe, baseband);
               test_errors++;
            end
      end
      reset = 1'b0;
      n = 0;
      do begin
         step();
         n++;
         if (!out_strobe) begin
            a_held_zero: assert (baseband == '0)
               else begin
                  $display("ERROR baseband before first strobe got %h expected 0", baseband);
                  test_errors++;
               end
         end
      end while (!out_strobe && n < 4*DECIM);
      a_first: assert (n == DECIM + 1)
         else begin
            $display("ERROR first out_strobe delay got %h expected %h", n, DECIM + 1);
            test_errors++;
         end
      finish_test("reset_state");

      // cadence, one pulse every DECIM cycles
      repeat (6) begin
         n = 0;
         do begin
            step();
            n++;
         end while (!out_strobe && n < 2*DECIM);
         a_period: assert (n == DECIM)
            else begin
               $display("ERROR out_strobe period got %h expected %h", n, DECIM);
               test_errors++;
            end
      end
      finish_test("cadence");

      repeat (3) begin   // no rotation
         si = rand_component(16000);
         sq = rand_component(16000);
         drive_and_settle(si, sq, '0, '0);
         check_iq(gain_scale(si), gain_scale(sq));
      end
      finish_test("dc_pass");

      si = big_component();
      sq = big_component();
      drive_and_settle(si, sq, '0, 20'h80000);   // pi
      check_iq(-gain_scale(si), -gain_scale(sq));
      drive_and_settle(si, sq, '0, 20'h40000);   // pi/2
      check_iq(-gain_scale(sq), gain_scale(si));
      drive_and_settle(si, sq, '0, 20'hc0000);   // -pi/2
      check_iq(gain_scale(sq), -gain_scale(si));
      finish_test("quadrants");

      // squared magnitude at random angles, within 0.2 %
      repeat (4) begin
         si = big_component();
         sq = big_component();
         drive_and_settle(si, sq, '0, PHASE_W'($urandom));
         exp_mag = g * g * (real'(si) * si + real'(sq) * sq);
         got_mag = real'(baseband.i) * baseband.i + real'(baseband.q) * baseband.q;
         got_l   = longint'(got_mag);
         exp_l   = longint'(exp_mag);
         a_mag: assert (got_mag >= 0.998 * exp_mag && got_mag <= 1.002 * exp_mag)
            else begin
               $display("ERROR baseband magnitude squared got %h expected %h", got_l, exp_l);
               test_errors++;
            end
      end
      finish_test("magnitude");

      // quarter turn per clock falls in a cic null
      si = rand_component(16000);
      sq = rand_component(16000);
      drive_and_settle(si, sq, 32'h4000_0000, '0);
      check_iq(0, 0);
      wait_strobe();
      check_iq(0, 0);
      finish_test("reject");

      if (dut.u_props.violations != 0) begin
         $display("bound assertions failed %0d times", dut.u_props.violations);
         fail_count += dut.u_props.violations;
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_passed, tests_run - tests_passed, fail_count);
      if (fail_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: build.f
hdl/ddc_pkg.sv
hdl/phase_accumulator.sv
hdl/cordic_rotator.sv
hdl/cic_decimator.sv
hdl/ddc_top.sv
bench/ddc_props.sv
bench/ddc_tb.sv

// File: hdl/cic_decimator.sv
`timescale 1ns/1ps

// three-stage cic decimator, ratio 2**DECIM_LOG2, differential delay 1
// dc gain 2**(3*DECIM_LOG2) is removed by a plain shift, net gain 1
module cic_decimator #(
   parameter int DECIM_LOG2 = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  ddc_pkg::iq_out_t mixed,
   output ddc_pkg::iq_out_t baseband,
   output logic             out_strobe
);
   import ddc_pkg::*;

   localparam int GROWTH = CIC_ORDER * DECIM_LOG2;   // bit growth of the filter
   localparam int CW     = OUT_W + GROWTH;           // internal word, wraps safely

   // index 0 is i, index 1 is q
   logic signed [OUT_W-1:0] x         [2];
   logic signed [CW-1:0]    integ     [2][CIC_ORDER];     // integrator state
   logic signed [CW-1:0]    comb_node [2][CIC_ORDER+1];   // comb chain taps
   logic signed [CW-1:0]    dly       [2][CIC_ORDER];     // comb delay registers
   logic signed [CW-1:0]    comb_q    [2];                // decimated result
   logic [DECIM_LOG2-1:0]   dcount;                       // decimation phase
   logic                    fire;                         // last input of a block
   logic                    fire_d;                       // combs just updated

   assign x    = '{mixed.i, mixed.q};
   assign fire = &dcount;

   // ########################################
   // integrators, full rate
   // ########################################
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < CIC_ORDER; s++) begin
               integ[c][s] <= '0;
            end
         end
      end else begin
         for (int c = 0; c < 2; c++) begin
            integ[c][0] <= integ[c][0] + CW'(x[c]);   // sign extended
            for (int s = 1; s < CIC_ORDER; s++) begin
               integ[c][s] <= integ[c][s] + integ[c][s-1];
            end
         end
      end
   end

   // decimation counter
   always_ff @(posedge clk) begin
      if (reset) begin
         dcount <= '0;
         fire_d <= 1'b0;
      end else begin
         dcount <= dcount + 1'b1;
         fire_d <= fire;
      end
   end

   // ########################################
   // combs, decimated rate
   // ########################################
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         comb_node[c][0] = integ[c][CIC_ORDER-1];
         for (int s = 0; s < CIC_ORDER; s++) begin
            comb_node[c][s+1] = comb_node[c][s] - dly[c][s];   // y[n] - y[n-1]
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int c = 0; c < 2; c++) begin
            comb_q[c] <= '0;
            for (int s = 0; s < CIC_ORDER; s++) begin
               dly[c][s] <= '0;
            end
         end
      end else if (fire) begin
         for (int c = 0; c < 2; c++) begin
            comb_q[c] <= comb_node[c][CIC_ORDER];
            for (int s = 0; s < CIC_ORDER; s++) begin
               dly[c][s] <= comb_node[c][s];
            end
         end
      end
   end

   // gain shift, output held until the next strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         baseband   <= '0;
         out_strobe <= 1'b0;
      end else begin
         out_strobe <= fire_d;   // one clock wide
         if (fire_d) begin
            baseband.i <= comb_q[0][CW-1 -: OUT_W];
            baseband.q <= comb_q[1][CW-1 -: OUT_W];
         end
      end
   end

endmodule

// File: hdl/cordic_rotator.sv
`timescale 1ns/1ps

// pipelined cordic vector rotator
//   i' = i*cos(a) - q*sin(a), q' = i*sin(a) + q*cos(a), gain about 3.2934
//   angle scale: pi radians = 2**19
//   latency CORDIC_LATENCY clocks, one new sample every clock
module cordic_rotator (
   input  logic                       clk,
   input  ddc_pkg::iq_in_t            sample,
   input  logic [ddc_pkg::PHASE_W-1:0] angle,
   output ddc_pkg::iq_out_t           rotated
);
   import ddc_pkg::*;

   localparam int CW   = SAMPLE_W + 4;   // sign extension + 3 guard bits
   localparam int DROP = CW - OUT_W;     // bits removed at the output

   // residual angle width entering stage k
   // 19 after the quadrant split, 18 twice, then one bit less per stage
   function automatic int ang_width(input int k);
      if (k == 0)
         return PHASE_W - 1;
      else if (k == 1)
         return PHASE_W - 2;
      else
         return PHASE_W - k;
   endfunction

   // drop the low bits, round half up
   function automatic logic [OUT_W-1:0] round_out(input logic [CW-1:0] v);
      return v[CW-1 -: OUT_W] + {{(OUT_W-1){1'b0}}, v[DROP-1]};
   endfunction

   logic signed [CW-1:0] wide_i, wide_q;   // widened input sample
   logic signed [CW-1:0] i0, q0;           // after quadrant pre-rotation

   assign wide_i = {sample.i[SAMPLE_W-1], sample.i, 3'd0};
   assign wide_q = {sample.q[SAMPLE_W-1], sample.q, 3'd0};

   // ########################################
   // quadrant pre-rotation
   // ########################################
   // quadrants 1 and 2 get a 180 degree flip, the residual angle is
   // then angle[18:0] read as signed, inside +-90 degrees
   always_ff @(posedge clk) begin
      case (angle[PHASE_W-1 -: 2])
         2'b01, 2'b10: begin
            i0 <= -wide_i;
            q0 <= -wide_q;
         end
         default: begin
            i0 <= wide_i;
            q0 <= wide_q;
         end
      endcase
   end

   // ########################################
   // micro-rotation stages
   // ########################################
   for (genvar k = 0; k < CORDIC_STAGES; k++) begin : stage
      localparam int AW = ang_width(k);

      logic [AW-1:0]        res;           // residual angle, level k
      logic signed [CW-1:0] xi_in, xq_in;  // vector at level k
      logic signed [CW-1:0] xi, xq;        // vector at level k+1

      if (k == 0) begin : g_head
         assign xi_in = i0;
         assign xq_in = q0;

         always_ff @(posedge clk) begin
            res <= angle[AW-1:0];   // aligned with i0/q0
         end
      end else begin : g_body
         localparam int AWP = ang_width(k-1);
         localparam logic [PHASE_W-3:0] ATAN = atan_table(k-1);

         assign xi_in = stage[k-1].xi;
         assign xq_in = stage[k-1].xq;

         // undo the previous stage's step, keep only the bits still needed
         always_ff @(posedge clk) begin
            if (stage[k-1].res[AWP-1])
               res <= stage[k-1].res[AW-1:0] + ATAN[AW-1:0];   // went too far
            else
               res <= stage[k-1].res[AW-1:0] - ATAN[AW-1:0];
         end
      end

      // shift-and-add, direction from the residual sign
      always_ff @(posedge clk) begin
         if (res[AW-1]) begin       // negative, rotate clockwise
            xi <= xi_in + (xq_in >>> k);
            xq <= xq_in - (xi_in >>> k);
         end else begin             // positive, rotate counterclockwise
            xi <= xi_in - (xq_in >>> k);
            xq <= xq_in + (xi_in >>> k);
         end
      end
   end

   // ########################################
   // output rounding
   // ########################################
   always_ff @(posedge clk) begin
      rotated.i <= round_out(stage[CORDIC_STAGES-1].xi);
      rotated.q <= round_out(stage[CORDIC_STAGES-1].xq);
   end

endmodule

// File: hdl/ddc_pkg.sv
package ddc_pkg;

   // ########################################
   // widths
   // ########################################
   localparam int SAMPLE_W = 16;        // adc sample component
   localparam int OUT_W    = 18;        // cordic and baseband component
   localparam int PHASE_W  = 20;        // pi radians = 2**19
   localparam int FREQ_W   = 32;        // nco tuning word and accumulator

   // ########################################
   // cordic and cic constants
   // ########################################
   localparam int CORDIC_STAGES   = 17;     // micro-rotations
   localparam int CORDIC_LATENCY  = 19;     // quadrant + 17 stages + rounding
   localparam int CORDIC_GAIN_NUM = 13490;  // 3.2934 * 4096
   localparam int CIC_ORDER       = 3;      // gain shift assumes three stages

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;
      logic signed [SAMPLE_W-1:0] q;
   } iq_in_t;

   typedef struct packed {
      logic signed [OUT_W-1:0] i;
      logic signed [OUT_W-1:0] q;
   } iq_out_t;

   // arctan(2**-n), scaled so that 45 degrees = 2**17
   function automatic logic [PHASE_W-3:0] atan_table(input int n);
      case (n)
         0:  return 18'd131072;   // 45.000 deg
         1:  return 18'd77376;    // 26.565 deg
         2:  return 18'd40884;    // 14.036 deg
         3:  return 18'd20753;    // 7.125 deg
         4:  return 18'd10417;
         5:  return 18'd5213;
         6:  return 18'd2607;
         7:  return 18'd1304;
         8:  return 18'd652;
         9:  return 18'd326;
         10: return 18'd163;
         11: return 18'd81;
         12: return 18'd41;
         13: return 18'd20;
         14: return 18'd10;
         15: return 18'd5;        // 0.00175 deg
         default: return '0;      // last stage needs no angle update
      endcase
   endfunction

endpackage

// File: hdl/ddc_top.sv
`timescale 1ns/1ps

// digital down-converter channel
// nco + cordic mixer followed by a cic decimator
module ddc_top #(
   parameter int DECIM_LOG2 = 4    // log2 of the decimation ratio
) (
   input  logic                       clk,
   input  logic                       reset,
   input  ddc_pkg::iq_in_t            sample_in,
   input  logic [ddc_pkg::FREQ_W-1:0]  freq_word,
   input  logic [ddc_pkg::PHASE_W-1:0] phase_offset,
   output ddc_pkg::iq_out_t           baseband,
   output logic                       out_strobe
);
   import ddc_pkg::*;

   iq_in_t             sample_d;   // sample lined up with its angle
   logic [PHASE_W-1:0] angle;      // nco phase, one clock behind
   iq_out_t            mixed;      // full-rate mixer output

   // ########################################
   // nco
   // ########################################
   phase_accumulator u_nco (
      .clk          (clk),
      .reset        (reset),
      .freq_word    (freq_word),
      .phase_offset (phase_offset),
      .angle        (angle)
   );

   // the angle register adds one clock, match it on the data side
   always_ff @(posedge clk) begin
      sample_d <= sample_in;
   end

   // ########################################
   // mixer and decimator
   // ########################################
   cordic_rotator u_mixer (
      .clk     (clk),
      .sample  (sample_d),
      .angle   (angle),
      .rotated (mixed)
   );

   cic_decimator #(
      .DECIM_LOG2 (DECIM_LOG2)
   ) u_cic (
      .clk        (clk),
      .reset      (reset),
      .mixed      (mixed),
      .baseband   (baseband),
      .out_strobe (out_strobe)
   );

endmodule

// File: hdl/phase_accumulator.sv
`timescale 1ns/1ps

// nco phase generator
// the accumulator wraps modulo 2**32, its top bits become the rotation angle
module phase_accumulator (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [ddc_pkg::FREQ_W-1:0]  freq_word,
   input  logic [ddc_pkg::PHASE_W-1:0] phase_offset,
   output logic [ddc_pkg::PHASE_W-1:0] angle
);
   import ddc_pkg::*;

   logic [FREQ_W-1:0]  acc;       // running phase, wraps naturally
   logic [PHASE_W-1:0] acc_top;   // truncated phase fed to the cordic

   assign acc_top = acc[FREQ_W-1 -: PHASE_W];

   // ########################################
   // phase register
   // ########################################
   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
      end else begin
         acc <= acc + freq_word;   // one step per clock
      end
   end

   // static offset added after truncation, wraps at 2 pi
   always_ff @(posedge clk) begin
      if (reset) begin
         angle <= '0;
      end else begin
         angle <= acc_top + phase_offset;
      end
   end

endmodule
